// File: bench/switchArbiterTb.sv
`timescale 1ns/10ps
`default_nettype none

`include "arbiter_config.svh"

module switchArbiterTb;

  import routerPkg::*;

  typedef flitKind_t [`NUM_PORTS-1:0] kindRow_t;
  typedef pktLen_t   [`NUM_PORTS-1:0] lenRow_t;
  typedef flit_t     [`NUM_PORTS-1:0] flitRow_t;

  localparam int        resetTimeout = 20;
  localparam int        noSrc        = -1;
  localparam flitKind_t kindHead     = flitKind_t'(`HEAD_KIND);
  localparam flitKind_t kindBody     = flitKind_t'(2);
  localparam kindRow_t  allBody      = {`NUM_PORTS{kindBody}};
  localparam kindRow_t  allHead      = {`NUM_PORTS{kindHead}};
  localparam lenRow_t   noLens       = '0;

  // Ports listed South down to Local.
  localparam kindRow_t firstKinds = {kindHead, kindBody, kindBody, kindHead, kindHead};
  localparam lenRow_t  firstLens  = {pktLen_t'(2), pktLen_t'(0), pktLen_t'(0),
                                     pktLen_t'(1), pktLen_t'(2)};

  logic      clk = 1'b0;
  logic      rst;
  flit_t     inFlit [`NUM_PORTS];
  portMask_t inReq;
  portMask_t grant;
  flit_t     outFlit;
  logic      outValid;

  logic [31:0] lfsr = 32'h427ecef6;
  int          checksDone = 0;

  // Stimulus table with one entry per clock cycle.
  string     nameQ[$];
  portMask_t reqQ[$];
  kindRow_t  kindQ[$];
  lenRow_t   lenQ[$];
  portMask_t grantExpQ[$];
  logic      validExpQ[$];
  int        fromQ[$];      // Port whose flit from two rows back shows up.
  flitRow_t  sentQ[$];

  switchArbiter dut (
    .clk      (clk),
    .rst      (rst),
    .inFlit   (inFlit),
    .inReq    (inReq),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

  always #10 clk = ~clk;

  initial
  begin
    rst <= 1'b1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
  end

  // Fibonacci LFSR with taps 32 22 2 1.
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic drawPayload(output pktLen_t val);
    val = '0;
    for (int b = 0; b < `LEN_WIDTH; b++)
    begin
      lfsr = lfsrStep(lfsr);
      val  = {val[`LEN_WIDTH-2:0], lfsr[0]};
    end
  endtask

  // Heads carry the table budget and body flits a random payload.
  task automatic buildRow(input int i, output flitRow_t row);
    pktLen_t payload;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      row[p].kind = kindQ[i][p];
      if (kindQ[i][p] == kindHead)
        row[p].len = lenQ[i][p];
      else
      begin
        drawPayload(payload);
        row[p].len = payload;
      end
    end
  endtask

  task automatic addRow(input string name, input portMask_t req, input kindRow_t kinds,
                        input lenRow_t lens, input portMask_t expGrant, input logic expValid,
                        input int expFrom);
    nameQ.push_back(name);
    reqQ.push_back(req);
    kindQ.push_back(kinds);
    lenQ.push_back(lens);
    grantExpQ.push_back(expGrant);
    validExpQ.push_back(expValid);
    fromQ.push_back(expFrom);
  endtask

  task automatic checkMask(input string name, input portMask_t exp, input portMask_t act);
    checksDone++;
    if (act !== exp)
    begin
      $display("** Error %s grant expected %b, actual %b", name, exp, act);
      $display("Testbench failed");
      $fatal(1, "grant mismatch");
    end
  endtask

  task automatic checkBit(input string name, input logic exp, input logic act);
    checksDone++;
    if (act !== exp)
    begin
      $display("** Error %s outValid expected %b, actual %b", name, exp, act);
      $display("Testbench failed");
      $fatal(1, "outValid mismatch");
    end
  endtask

  task automatic checkFlit(input string name, input flit_t exp, input flit_t act);
    checksDone++;
    if (act !== exp)
    begin
      $display("** Error %s outFlit expected kind %0d len %h, actual kind %0d len %h",
               name, exp.kind, exp.len, act.kind, act.len);
      $display("Testbench failed");
      $fatal(1, "outFlit mismatch");
    end
  endtask

  // Grant lags the request by two rows while outValid and outFlit lag by three.
  task automatic loadTable();
    addRow("idle", 5'b00000, allBody, noLens, 5'b00000, 1'b0, noSrc);
    addRow("idle", 5'b00000, allBody, noLens, 5'b00000, 1'b0, noSrc);
    addRow("idle", 5'b00000, allBody, noLens, 5'b00000, 1'b0, noSrc);
    addRow("idle", 5'b00000, allBody, noLens, 5'b00000, 1'b0, noSrc);
    addRow("heads", 5'b10011, firstKinds, firstLens, 5'b00000, 1'b0, noSrc);
    addRow("heads", 5'b10011, allBody, noLens, 5'b00000, 1'b0, noSrc);
    addRow("lowest wins", 5'b10011, allBody, noLens, 5'b00001, 1'b0, noSrc);
    addRow("local hold", 5'b10011, allBody, noLens, 5'b00001, 1'b1, 0);
    addRow("local hold", 5'b10011, allBody, noLens, 5'b00001, 1'b1, 0);
    addRow("north next", 5'b10011, allBody, noLens, 5'b00010, 1'b1, 0);
    addRow("north hold", 5'b10011, allBody, noLens, 5'b00010, 1'b1, 1);
    addRow("south next", 5'b00011, allBody, noLens, 5'b10000, 1'b1, 1);
    addRow("south hold", 5'b00010, allBody, noLens, 5'b10000, 1'b1, 4);
    addRow("south drop", 5'b00000, allBody, noLens, 5'b00001, 1'b0, noSrc);  // Wraps to Local.
    addRow("local drop", 5'b00000, allBody, noLens, 5'b00010, 1'b0, noSrc);
    addRow("none left", 5'b00000, allBody, noLens, 5'b00000, 1'b0, noSrc);
    // Budget 0 everywhere from here on.
    addRow("zero heads", 5'b00000, allHead, noLens, 5'b00000, 1'b0, noSrc);
    addRow("all request", 5'b11111, allBody, noLens, 5'b00000, 1'b0, noSrc);
    addRow("all request", 5'b11111, allBody, noLens, 5'b00000, 1'b0, noSrc);
    addRow("rr local", 5'b11111, allBody, noLens, 5'b00001, 1'b0, noSrc);
    addRow("rr north", 5'b11111, allBody, noLens, 5'b00010, 1'b1, 0);
    addRow("rr east", 5'b11111, allBody, noLens, 5'b00100, 1'b1, 1);
    addRow("rr west", 5'b10101, allBody, noLens, 5'b01000, 1'b1, 2);
    addRow("rr south", 5'b10101, allBody, noLens, 5'b10000, 1'b1, 3);
    addRow("rr wrap", 5'b10101, allBody, noLens, 5'b00001, 1'b1, 4);
    addRow("rr skip", 5'b10101, allBody, noLens, 5'b00100, 1'b1, 0);
    addRow("rr skip", 5'b00000, allBody, noLens, 5'b10000, 1'b1, 2);
    addRow("rr wrap", 5'b00000, allBody, noLens, 5'b00001, 1'b1, 4);
    addRow("rr end", 5'b00000, allBody, noLens, 5'b00000, 1'b0, noSrc);
    addRow("rr end", 5'b00000, allBody, noLens, 5'b00000, 1'b0, noSrc);
    addRow("quiet", 5'b00000, allBody, noLens, 5'b00000, 1'b0, noSrc);
  endtask

  initial
  begin
    string    testName;
    int       waitCount;
    flitRow_t row;
    flit_t    expFlit;
    inReq <= '0;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      inFlit[p] <= '0;
    end
    loadTable();

    waitCount = 0;
    while (rst !== 1'b0)
    begin
      @(negedge clk);
      waitCount++;
      if (waitCount > resetTimeout)
      begin
        $display("Reset did not release within %0d cycles", resetTimeout);
        $display("Testbench failed");
        $fatal(1, "reset timeout");
      end
    end

    for (int i = 0; i < nameQ.size(); i++)
    begin
      buildRow(i, row);
      @(posedge clk);
      for (int p = 0; p < `NUM_PORTS; p++)
      begin
        inFlit[p] <= row[p];
      end
      inReq <= reqQ[i];
      sentQ.push_back(row);

      @(negedge clk);  // Outputs settled.
      testName = $sformatf("%s (row %0d)", nameQ[i], i);
      checkMask(testName, grantExpQ[i], grant);
      checkBit(testName, validExpQ[i], outValid);
      if (validExpQ[i] && (i < 2 || fromQ[i] == noSrc))
      begin
        $display("Row %0d expects output data but names no source port", i);
        $display("Testbench failed");
        $fatal(1, "bad table row");
      end
      else if (validExpQ[i])
      begin
        expFlit = sentQ[i-2][fromQ[i]];
        checkFlit(testName, expFlit, outFlit);
      end
    end

    if (checksDone > 0)
    begin
      $display("Testbench passed");
      $finish;
    end
    else
    begin
      $display("Testbench failed");
      $fatal(1, "the stimulus table ran no checks");
    end
  end

endmodule

`default_nettype wire

// File: include/arbiter_config.svh
`ifndef ARBITER_CONFIG_SVH
`define ARBITER_CONFIG_SVH

// Input ports Local, North, East, West, South.
`define NUM_PORTS 5

// Flit fields.
`define KIND_WIDTH 3
`define LEN_WIDTH 12

// Kind code of a head flit.
`define HEAD_KIND 1

`endif

// File: logic/flitClassifier.sv
`timescale 1ns/10ps
`default_nettype none

`include "arbiter_config.svh"

module flitClassifier (
  input  logic                   clk,
  input  logic                   rst,
  input  routerPkg::flit_t       inFlit [`NUM_PORTS],
  input  routerPkg::portMask_t   inReq,
  output routerPkg::portStatus_t status [`NUM_PORTS]
);

  import routerPkg::*;

  portStatus_t nextStatus [`NUM_PORTS];

  // Head detection works on the raw kind field.
  always_comb
  begin
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      nextStatus[p].flit   = inFlit[p];
      nextStatus[p].req    = inReq[p];
      nextStatus[p].isHead = (inFlit[p].kind == flitKind_t'(`HEAD_KIND));
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int p = 0; p < `NUM_PORTS; p++)
      begin
        status[p] <= '0;
      end
    end
    else
    begin
      for (int p = 0; p < `NUM_PORTS; p++)
      begin
        status[p] <= nextStatus[p];
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/grantScheduler.sv
`timescale 1ns/10ps
`default_nettype none

`include "arbiter_config.svh"

module grantScheduler (
  input  logic                   clk,
  input  logic                   rst,
  input  routerPkg::portStatus_t status [`NUM_PORTS],
  input  routerPkg::portMask_t   timesUp,
  output routerPkg::portMask_t   runTimer,
  output routerPkg::portMask_t   grant,
  output routerPkg::flit_t       outFlit,
  output logic                   outValid
);

  import routerPkg::*;

  schedState_t state;
  schedState_t stateNext;
  portIdx_t    holder;      // Port that owns the output while busy.
  portIdx_t    holderNext;
  portMask_t   reqMask;
  logic        anyReq;
  logic        holderReq;

  // First requesting port after last, wrapping. Last itself comes at the very end.
  function automatic portIdx_t rotatePick(input portMask_t req, input portIdx_t last);
    portIdx_t pick;
    int       idx;
    pick = last;
    // Nearest candidate is checked last so that it wins.
    for (int off = `NUM_PORTS; off >= 1; off--)
    begin
      idx = (int'(last) + off) % `NUM_PORTS;
      if (req[idx])
        pick = portIdx_t'(idx);
    end
    return pick;
  endfunction

  always_comb
  begin
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      reqMask[p] = status[p].req;
    end
  end

  assign anyReq    = |reqMask;
  assign holderReq = reqMask[holder];

  always_comb
  begin
    stateNext  = state;
    holderNext = holder;
    runTimer   = '0;
    case (state)
      sIdle:
      begin
        // Starting after the highest port gives Local first pick.
        if (anyReq)
        begin
          stateNext  = sBusy;
          holderNext = rotatePick(reqMask, portIdx_t'(`NUM_PORTS - 1));
        end
      end
      sBusy:
      begin
        if (holderReq && !timesUp[holder])
          runTimer[holder] = 1'b1;  // Keep the port and count.
        else if (anyReq)
          holderNext = rotatePick(reqMask, holder);
        else
          stateNext = sIdle;
      end
      default:
      begin
        stateNext = sIdle;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state  <= sIdle;
      holder <= '0;
    end
    else
    begin
      state  <= stateNext;
      holder <= holderNext;
    end
  end

  // One-hot grant from the registered state.
  always_comb
  begin
    grant = '0;
    if (state == sBusy)
      grant[holder] = 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= (state == sBusy) && holderReq;
  end

  // Flit only moves on a granted, requesting cycle.
  always_ff @(posedge clk)
  begin
    if ((state == sBusy) && holderReq)
      outFlit <= status[holder].flit;
  end

endmodule

`default_nettype wire

// File: logic/packetTimer.sv
`timescale 1ns/10ps
`default_nettype none

module packetTimer (
  input  logic               clk,
  input  logic               rst,
  input  logic               isHead,
  input  routerPkg::pktLen_t headLen,
  input  logic               runTimer,
  output logic               timesUp
);

  import routerPkg::*;

  pktLen_t budget;  // Len of the last head flit.
  pktLen_t count;   // Cycles used by the current holder.

  always_ff @(posedge clk)
  begin
    if (rst)
      budget <= '0;
    else if (isHead)
      budget <= headLen;
  end

  // Restarts whenever the port is not held.
  always_ff @(posedge clk)
  begin
    if (rst)
      count <= '0;
    else if (runTimer)
      count <= count + 1'b1;
    else
      count <= '0;
  end

  assign timesUp = (count == budget);  // Last cycle of the hold.

endmodule

`default_nettype wire

// File: logic/routerPkg.sv
`default_nettype none

`include "arbiter_config.svh"

package routerPkg;

  // Flit kind code.
  typedef logic [`KIND_WIDTH-1:0] flitKind_t;

  // Budget in a head flit, payload otherwise.
  typedef logic [`LEN_WIDTH-1:0] pktLen_t;

  typedef struct packed {
    flitKind_t kind;
    pktLen_t   len;
  } flit_t;

  // Port number, 0 is Local.
  typedef logic [$clog2(`NUM_PORTS)-1:0] portIdx_t;

  // One bit per input port.
  typedef logic [`NUM_PORTS-1:0] portMask_t;

  // Registered view of one input port.
  typedef struct packed {
    flit_t flit;
    logic  req;
    logic  isHead;
  } portStatus_t;

  typedef enum logic {
    sIdle,
    sBusy
  } schedState_t;

endpackage

`default_nettype wire

// File: logic/switchArbiter.sv
`timescale 1ns/10ps
`default_nettype none

`include "arbiter_config.svh"

module switchArbiter (
  input  logic                 clk,
  input  logic                 rst,
  input  routerPkg::flit_t     inFlit [`NUM_PORTS],
  input  routerPkg::portMask_t inReq,
  output routerPkg::portMask_t grant,
  output routerPkg::flit_t     outFlit,
  output logic                 outValid
);

  import routerPkg::*;

  portStatus_t status [`NUM_PORTS];
  portMask_t   timesUp;
  portMask_t   runTimer;

  flitClassifier uClassifier (
    .clk    (clk),
    .rst    (rst),
    .inFlit (inFlit),
    .inReq  (inReq),
    .status (status)
  );

  // One hold timer per input port.
  for (genvar p = 0; p < `NUM_PORTS; p++)
  begin : gTimer
    packetTimer uTimer (
      .clk      (clk),
      .rst      (rst),
      .isHead   (status[p].isHead),
      .headLen  (status[p].flit.len),
      .runTimer (runTimer[p]),
      .timesUp  (timesUp[p])
    );
  end

  grantScheduler uScheduler (
    .clk      (clk),
    .rst      (rst),
    .status   (status),
    .timesUp  (timesUp),
    .runTimer (runTimer),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Compile and run the switch arbiter testbench with Verilator.
# The run passes only if the simulation log holds the pass line.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -j 0 --top-module switchArbiterTb -o simv \
  -f switchArbiter.f \
  && ./obj_dir/simv > sim.log 2>&1

cat sim.log 2>/dev/null
grep -qx "Testbench passed" sim.log 2>/dev/null \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

// File: switchArbiter.f
+incdir+include
logic/routerPkg.sv
logic/flitClassifier.sv
logic/packetTimer.sv
logic/grantScheduler.sv
logic/switchArbiter.sv
bench/switchArbiterTb.sv
